// ==== flist.f ====
design/iob_pkg.sv
design/msg_rx.sv
design/msg_tx.sv
design/iob_ctrl.sv
design/bus_arbiter.sv
design/bus_mem.sv
design/iob_top.sv
verif/iob_tb_sva.sv
verif/iob_tb.sv

// ==== verif/iob_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module iob_tb import iob_pkg::*; ();

	localparam int MEM_WORDS = 256;
	localparam int TIMEOUT = 2000;      // cycles for one handshake step
	localparam int IDLE_LIMIT = 100000; // link may sit idle this long
	localparam int L_RX_ACK = 0;
	localparam int L_TX_REQ = 1;
	localparam int L_LOC_ACK = 2;

	logic clk_sys, reset;
	logic rx_req, rx_ack, tx_req, tx_ack;
	logic [7:0] rx_byte, tx_byte;
	logic loc_req, loc_we, loc_ack;
	logic [15:0] loc_addr, loc_wdata, loc_rdata;
	bus_status_t loc_status;

	logic [15:0] model_mem [MEM_WORDS]; // what the memory should hold
	logic [47:0] exp_q[$];              // expected response frames, request order
	logic [47:0] rcv_q[$];              // frames collected from tx side
	int max_ack_delay = 2;

	iob_top #(.MEM_WORDS(MEM_WORDS)) iob_top_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys; // 4 ns period
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "stopped at %0t ns", $time);
	endtask

	task automatic check(input string what, input logic [47:0] got, input logic [47:0] exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t ns: %s, got %h expected %h",
				$time, what, got, exp));
	endtask

	function automatic logic line(input int sel);
		case (sel)
			L_RX_ACK: return rx_ack;
			L_TX_REQ: return tx_req;
			default: return loc_ack;
		endcase
	endfunction

	// polls one handshake line on falling edges
	task automatic wait_line(input int sel, input logic level, input int limit, input string what);
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
			if (n > limit)
				fail_run($sformatf("timeout waiting for %s", what));
		end while (line(sel) !== level);
	endtask

	function automatic logic [15:0] fill_word(input logic [15:0] a);
		return (a * 16'h9e37) ^ 16'h3c5a; // odd multiplier, all address bits count
	endfunction

	// response frame for one request, model memory updated on a good write
	function automatic logic [47:0] expected_response(input logic [47:0] req);
		logic [7:0] cmd;
		logic [15:0] addr, rdata;
		logic [3:0] code;
		cmd = req[47:40];
		addr = req[31:16];
		rdata = 16'h0000; // pe and en carry zero
		if (!cmd[7] || (cmd[3:0] != req_r && cmd[3:0] != req_w))
			code = resp_en;
		else if (addr >= MEM_WORDS)
			code = resp_pe;
		else begin
			code = resp_ok;
			if (cmd[3:0] == req_w) begin
				model_mem[addr] = req[15:0];
				rdata = req[15:0];
			end else
				rdata = model_mem[addr];
		end
		return {1'b0, 3'b000, code, req[39:32], addr, rdata}; // a1 and addr echoed
	endfunction

	task automatic link_request(input logic [7:0] cmd, input logic [7:0] a1,
			input logic [15:0] addr, input logic [15:0] data);
		logic [47:0] frame;
		frame = {cmd, a1, addr, data};
		exp_q.push_back(expected_response(frame));
		@(negedge clk_sys);
		for (int i = MSG_BYTES - 1; i >= 0; i--) begin
			rx_byte = frame[i*8 +: 8]; // cmd byte first
			rx_req = 1'b1;
			wait_line(L_RX_ACK, 1'b1, TIMEOUT, "rx_ack high");
			rx_req = 1'b0;
			wait_line(L_RX_ACK, 1'b0, TIMEOUT, "rx_ack low");
		end
	endtask

	task automatic loc_access(input logic we, input logic [15:0] addr, input logic [15:0] wdata);
		logic [47:0] exp;
		exp = expected_response({1'b1, 3'b000, we ? req_w : req_r, 8'h00, addr, wdata});
		@(negedge clk_sys);
		loc_we = we;
		loc_addr = addr;
		loc_wdata = wdata;
		loc_req = 1'b1;
		wait_line(L_LOC_ACK, 1'b1, TIMEOUT, "loc_ack high");
		check("local status", 48'(loc_status),
			(exp[43:40] == resp_ok) ? 48'(bus_ok) : 48'(bus_pe));
		if (!we || exp[43:40] != resp_ok) // write data return not defined
			check("local read data", 48'(loc_rdata), 48'(exp[15:0]));
		repeat ($urandom_range(3)) @(negedge clk_sys); // master lingers on req
		loc_req = 1'b0;
		wait_line(L_LOC_ACK, 1'b0, TIMEOUT, "loc_ack low");
	endtask

	task automatic random_link_request();
		logic [7:0] cmd;
		logic [15:0] addr;
		int pick;
		pick = $urandom_range(9);
		cmd = {1'b1, 3'b000, pick[0] ? req_w : req_r};
		addr = 16'($urandom_range(127)); // low half, link only
		if (pick == 9)
			cmd = 8'h05; // flag clear
		if (pick == 8)
			addr = 16'h0100 + 16'($urandom_range(255)); // past the end
		link_request(cmd, 8'($urandom_range(15)), addr, 16'($urandom));
	endtask

	task automatic random_loc_access();
		logic [15:0] addr;
		addr = 16'(128 + $urandom_range(127)); // high half, local only
		if ($urandom_range(7) == 0)
			addr = 16'h8000 | 16'($urandom);
		loc_access(1'($urandom_range(1)), addr, 16'($urandom));
	endtask

	task automatic wait_responses();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk_sys);
			n++;
			if (n > IDLE_LIMIT)
				fail_run("timeout waiting for outstanding response frames");
		end
	endtask

	// far end of the tx link, random ack delay per byte
	initial begin : link_sink
		logic [47:0] frame;
		tx_ack = 1'b0;
		forever begin
			for (int i = 0; i < MSG_BYTES; i++) begin
				wait_line(L_TX_REQ, 1'b1, (i == 0) ? IDLE_LIMIT : TIMEOUT, "tx_req from DUT");
				frame = {frame[39:0], tx_byte}; // cmd byte arrives first
				repeat ($urandom_range(max_ack_delay)) @(negedge clk_sys);
				tx_ack = 1'b1;
				wait_line(L_TX_REQ, 1'b0, TIMEOUT, "tx_req low after tx_ack");
				tx_ack = 1'b0;
			end
			rcv_q.push_back(frame);
		end
	end

	initial begin : compare_frames
		logic [47:0] got;
		int n;
		forever begin
			n = 0;
			while (rcv_q.size() == 0) begin
				@(negedge clk_sys);
				n++;
				if (n > IDLE_LIMIT)
					fail_run("timeout waiting for a response frame");
			end
			got = rcv_q.pop_front();
			if (exp_q.size() == 0)
				fail_run("response frame arrived with no request outstanding");
			check("response frame", got, exp_q.pop_front());
		end
	end

	initial begin
		void'($urandom(32'h4d1dd09d));
		reset = 1'b1;
		rx_req = 1'b0;
		rx_byte = 8'h00;
		loc_req = 1'b0;
		loc_we = 1'b0;
		loc_addr = 16'h0000;
		loc_wdata = 16'h0000;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
		for (int a = 0; a < MEM_WORDS; a++) // known contents everywhere
			loc_access(1'b1, 16'(a), fill_word(16'(a)));
		link_request({1'b1, 3'b000, req_w}, 8'h03, 16'h0042, 16'hbeef);
		link_request({1'b1, 3'b000, req_r}, 8'h0c, 16'h0042, 16'h0000);
		link_request({1'b1, 3'b000, req_w}, 8'h01, 16'h0105, 16'h1234); // would alias 0x05
		link_request({1'b1, 3'b000, req_r}, 8'h01, 16'hffff, 16'h0000);
		link_request({1'b1, 3'b000, req_r}, 8'h02, 16'h0005, 16'h0000);
		link_request(8'h02, 8'h00, 16'h0010, 16'hdead); // response view of w
		link_request(8'h87, 8'h00, 16'h0010, 16'hdead); // unknown code
		link_request({1'b1, 3'b000, req_r}, 8'h00, 16'h0010, 16'h0000);
		loc_access(1'b1, 16'h0020, 16'h5a5a);
		link_request({1'b1, 3'b000, req_r}, 8'h04, 16'h0020, 16'h0000);
		link_request({1'b1, 3'b000, req_w}, 8'h04, 16'h0021, 16'hc3c3);
		wait_responses();
		loc_access(1'b0, 16'h0021, 16'h0000);
		fork
			for (int k = 0; k < 24; k++)
				random_link_request();
			for (int k = 0; k < 40; k++)
				random_loc_access();
		join
		wait_responses();
		max_ack_delay = 20; // slow far end, back-pressure up to rx
		for (int k = 0; k < 16; k++)
			random_link_request();
		wait_responses();
		if (iob_top_inst.iob_tb_sva_inst.fail_count == 0) begin
			$display("TEST PASSED");
			$finish;
		end else
			fail_run("bound handshake assertions failed");
	end

endmodule

`default_nettype wire

// ==== verif/iob_tb_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module iob_tb_sva (
	input logic       clk_sys,
	input logic       reset,
	input logic       rx_req,
	input logic       rx_ack,
	input logic       tx_req,
	input logic       tx_ack,
	input logic [7:0] tx_byte,
	input logic       loc_req,
	input logic       loc_ack
);

	int fail_count = 0; // failed assertions so far

	// registered ack, far end drops req half a cycle later
	rx_req_hold: assert property (@(posedge clk_sys) disable iff (reset)
		rx_req && !rx_ack |=> rx_req || rx_ack)
		else begin $error("rx_req dropped before rx_ack"); fail_count++; end

	tx_req_hold: assert property (@(posedge clk_sys) disable iff (reset)
		tx_req && !tx_ack |=> tx_req)
		else begin $error("tx_req dropped before tx_ack"); fail_count++; end

	// byte frozen under req
	tx_byte_stable: assert property (@(posedge clk_sys) disable iff (reset)
		tx_req |=> !tx_req || $stable(tx_byte))
		else begin $error("tx_byte moved while tx_req high"); fail_count++; end

	rx_ack_cause: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(rx_ack) |-> $past(rx_req))
		else begin $error("rx_ack rose without rx_req"); fail_count++; end

	tx_ack_cause: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(tx_ack) |-> tx_req)
		else begin $error("tx_ack rose without tx_req"); fail_count++; end

	loc_ack_cause: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(loc_ack) |-> $past(loc_req))
		else begin $error("loc_ack rose without loc_req"); fail_count++; end

	// ack held as long as the master holds req
	loc_ack_hold: assert property (@(posedge clk_sys) disable iff (reset)
		loc_ack && loc_req |=> loc_ack)
		else begin $error("loc_ack fell while loc_req high"); fail_count++; end

endmodule

bind iob_top iob_tb_sva iob_tb_sva_inst (.*);

`default_nettype wire

// ==== design/iob_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module iob_top import iob_pkg::*; #(
	parameter int MEM_WORDS = 256
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        rx_req,
	input  logic [7:0]  rx_byte,
	output logic        rx_ack,
	output logic        tx_req,
	output logic [7:0]  tx_byte,
	input  logic        tx_ack,
	input  logic        loc_req,
	input  logic        loc_we,
	input  logic [15:0] loc_addr,
	input  logic [15:0] loc_wdata,
	output logic        loc_ack,
	output logic [15:0] loc_rdata,
	output bus_status_t loc_status
);

	localparam int ADDR_BITS = 16;

	// received frame
	logic msg_valid, rx_release;
	msg_cmd_t m_cmd;
	logic [7:0] m_a1;
	logic [15:0] m_addr, m_data;

	// response frame
	logic send_req, send_ack;
	msg_cmd_t t_cmd;
	logic [7:0] t_a1;
	logic [15:0] t_addr, t_data;

	// controller side of the bus
	logic m0_req, m0_ack, m0_we;
	logic [15:0] m0_addr, m0_wdata, m0_rdata;
	bus_status_t m0_status;

	// memory bus
	logic mem_stb, mem_we, mem_done;
	logic [15:0] mem_addr, mem_wdata, mem_rdata;
	bus_status_t mem_status;

	msg_rx msg_rx_inst (
		.clk_sys, .reset,
		.rx_req, .rx_byte, .rx_ack,
		.msg_valid, .m_cmd, .m_a1, .m_addr, .m_data,
		.rx_release
	);

	iob_ctrl iob_ctrl_inst (
		.clk_sys, .reset,
		.msg_valid, .m_cmd, .m_a1, .m_addr, .m_data,
		.rx_release,
		.m0_req, .m0_ack, .m0_addr, .m0_wdata, .m0_we, .m0_rdata, .m0_status,
		.send_req, .send_ack,
		.t_cmd, .t_a1, .t_addr, .t_data
	);

	msg_tx msg_tx_inst (
		.clk_sys, .reset,
		.send_req, .send_ack,
		.t_cmd, .t_a1, .t_addr, .t_data,
		.tx_req, .tx_byte, .tx_ack
	);

	// local master on the m1 side
	bus_arbiter #(.ADDR_BITS(ADDR_BITS)) bus_arbiter_inst (
		.clk_sys, .reset,
		.m0_req, .m0_we, .m0_addr, .m0_wdata, .m0_ack, .m0_rdata, .m0_status,
		.m1_req(loc_req), .m1_we(loc_we), .m1_addr(loc_addr), .m1_wdata(loc_wdata),
		.m1_ack(loc_ack), .m1_rdata(loc_rdata), .m1_status(loc_status),
		.mem_stb, .mem_we, .mem_addr, .mem_wdata,
		.mem_done, .mem_rdata, .mem_status
	);

	bus_mem #(.MEM_WORDS(MEM_WORDS), .ADDR_BITS(ADDR_BITS)) bus_mem_inst (
		.clk_sys, .reset,
		.mem_stb, .mem_we, .mem_addr, .mem_wdata,
		.mem_done, .mem_rdata, .mem_status
	);

endmodule

`default_nettype wire

// ==== design/bus_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_mem import iob_pkg::*; #(
	parameter int MEM_WORDS = 256,
	parameter int ADDR_BITS = 16
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 mem_stb,
	input  logic                 mem_we,
	input  logic [ADDR_BITS-1:0] mem_addr,
	input  logic [15:0]          mem_wdata,
	output logic                 mem_done,
	output logic [15:0]          mem_rdata,
	output bus_status_t          mem_status
);

	localparam int IDX_BITS = $clog2(MEM_WORDS);

	logic [15:0] mem [MEM_WORDS];
	logic [IDX_BITS-1:0] idx;
	logic in_range;

	assign idx = mem_addr[IDX_BITS-1:0];
	assign in_range = (32'(mem_addr) < MEM_WORDS); // memory starts at zero

	// done one cycle after strobe
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_done <= 1'b0;
			mem_status <= bus_none;
		end else begin
			mem_done <= mem_stb;
			if (mem_stb)
				mem_status <= in_range ? bus_ok : bus_pe;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (mem_stb) begin
			if (in_range) begin
				if (mem_we)
					mem[idx] <= mem_wdata;
				mem_rdata <= mem[idx]; // old word on a write
			end else begin
				mem_rdata <= 16'h0000; // out of range, nothing touched
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import iob_pkg::*; #(
	parameter int ADDR_BITS = 16
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 m0_req,
	input  logic                 m0_we,
	input  logic [ADDR_BITS-1:0] m0_addr,
	input  logic [15:0]          m0_wdata,
	output logic                 m0_ack,
	output logic [15:0]          m0_rdata,
	output bus_status_t          m0_status,
	input  logic                 m1_req,
	input  logic                 m1_we,
	input  logic [ADDR_BITS-1:0] m1_addr,
	input  logic [15:0]          m1_wdata,
	output logic                 m1_ack,
	output logic [15:0]          m1_rdata,
	output bus_status_t          m1_status,
	output logic                 mem_stb,
	output logic                 mem_we,
	output logic [ADDR_BITS-1:0] mem_addr,
	output logic [15:0]          mem_wdata,
	input  logic                 mem_done,
	input  logic [15:0]          mem_rdata,
	input  bus_status_t          mem_status
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_STB  = 2'd1; // strobe cycle
	localparam logic [1:0] ST_WAIT = 2'd2; // waiting for done
	localparam logic [1:0] ST_ACK  = 2'd3; // ack up until req falls

	logic [1:0] state;
	logic gnt;      // 1 = local master
	logic last_gnt; // master served last, loses a tie
	logic pick;
	logic gnt_req;

	assign pick = (m0_req && m1_req) ? ~last_gnt : m1_req;
	assign gnt_req = gnt ? m1_req : m0_req;

	assign mem_stb = (state == ST_STB);
	assign mem_we = gnt ? m1_we : m0_we;
	assign mem_addr = gnt ? m1_addr : m0_addr;
	assign mem_wdata = gnt ? m1_wdata : m0_wdata;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= ST_IDLE;
			gnt <= 1'b0;
			last_gnt <= 1'b1; // master 0 wins the first tie
			m0_ack <= 1'b0;
			m1_ack <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (m0_req || m1_req) begin
					gnt <= pick;
					last_gnt <= pick;
					state <= ST_STB;
				end
				ST_STB: state <= ST_WAIT;
				ST_WAIT: if (mem_done) begin
					if (gnt)
						m1_ack <= 1'b1;
					else
						m0_ack <= 1'b1;
					state <= ST_ACK;
				end
				ST_ACK: if (!gnt_req) begin
					m0_ack <= 1'b0;
					m1_ack <= 1'b0;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// reply routed back to the granted master only
	always_ff @(posedge clk_sys) begin
		if (state == ST_WAIT && mem_done) begin
			if (gnt) begin
				m1_rdata <= mem_rdata;
				m1_status <= mem_status;
			end else begin
				m0_rdata <= mem_rdata;
				m0_status <= mem_status;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/iob_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module iob_ctrl import iob_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        msg_valid,
	input  msg_cmd_t    m_cmd,
	input  logic [7:0]  m_a1,
	input  logic [15:0] m_addr,
	input  logic [15:0] m_data,
	output logic        rx_release,
	output logic        m0_req,
	input  logic        m0_ack,
	output logic [15:0] m0_addr,
	output logic [15:0] m0_wdata,
	output logic        m0_we,
	input  logic [15:0] m0_rdata,
	input  bus_status_t m0_status,
	output logic        send_req,
	input  logic        send_ack,
	output msg_cmd_t    t_cmd,
	output logic [7:0]  t_a1,
	output logic [15:0] t_addr,
	output logic [15:0] t_data
);

	localparam logic [2:0] ST_IDLE    = 3'd0;
	localparam logic [2:0] ST_DECODE  = 3'd1;
	localparam logic [2:0] ST_BUS     = 3'd2;
	localparam logic [2:0] ST_RESPOND = 3'd3;
	localparam logic [2:0] ST_WAIT    = 3'd4; // response on the link
	localparam logic [2:0] ST_RELEASE = 3'd5;

	logic [2:0] state;
	logic access;     // request went to the bus
	logic bus_good;   // slave answered ok
	logic [15:0] bus_rd;
	logic is_rw;

	// request view, flag set and a known code
	assign is_rw = m_cmd.req.dir &&
		(m_cmd.req.code == req_r || m_cmd.req.code == req_w);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= ST_IDLE;
			access <= 1'b0;
			m0_req <= 1'b0;
			send_req <= 1'b0;
			rx_release <= 1'b0;
		end else begin
			rx_release <= 1'b0; // single cycle pulse
			case (state)
				ST_IDLE: if (msg_valid && !m0_ack)
					state <= ST_DECODE;
				ST_DECODE: begin
					access <= is_rw;
					if (is_rw) begin
						m0_req <= 1'b1;
						state <= ST_BUS;
					end else begin
						state <= ST_RESPOND; // refused, no bus cycle
					end
				end
				ST_BUS: if (m0_ack) begin
					m0_req <= 1'b0; // arbiter drops ack after this
					state <= ST_RESPOND;
				end
				ST_RESPOND: begin
					send_req <= 1'b1;
					state <= ST_WAIT;
				end
				ST_WAIT: if (send_ack) begin
					send_req <= 1'b0;
					rx_release <= 1'b1; // fields already copied into t_*
					state <= ST_RELEASE;
				end
				ST_RELEASE: if (!send_ack && !m0_ack && !msg_valid)
					state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// bus request fields, stable while m0_req is up
	always_ff @(posedge clk_sys) begin
		if (state == ST_DECODE) begin
			m0_addr <= m_addr;
			m0_wdata <= m_data;
			m0_we <= (m_cmd.req.code == req_w);
		end
	end

	// slave reply, taken with ack
	always_ff @(posedge clk_sys) begin
		if (state == ST_BUS && m0_ack) begin
			bus_good <= (m0_status == bus_ok);
			bus_rd <= m0_rdata;
		end
	end

	// response frame, echoes a1 and address
	always_ff @(posedge clk_sys) begin
		if (state == ST_RESPOND) begin
			t_cmd.resp.dir <= 1'b0;
			t_cmd.resp.rsvd <= 3'b000;
			if (!access)
				t_cmd.resp.code <= resp_en;
			else
				t_cmd.resp.code <= bus_good ? resp_ok : resp_pe;
			t_a1 <= m_a1;
			t_addr <= m_addr;
			if (access && bus_good)
				t_data <= m0_we ? m0_wdata : bus_rd; // written or read word
			else
				t_data <= 16'h0000; // pe and en carry no data
		end
	end

endmodule

`default_nettype wire

// ==== design/msg_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module msg_tx import iob_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        send_req,
	output logic        send_ack,
	input  msg_cmd_t    t_cmd,
	input  logic [7:0]  t_a1,
	input  logic [15:0] t_addr,
	input  logic [15:0] t_data,
	output logic        tx_req,
	output logic [7:0]  tx_byte,
	input  logic        tx_ack
);

	localparam int CNT_BITS = $clog2(MSG_BYTES);
	localparam logic [CNT_BITS-1:0] LAST = CNT_BITS'(MSG_BYTES - 1);

	localparam logic [1:0] TX_IDLE = 2'd0;
	localparam logic [1:0] TX_BYTE = 2'd1; // req high, waiting for ack
	localparam logic [1:0] TX_GAP  = 2'd2; // req low, waiting for ack to drop
	localparam logic [1:0] TX_DONE = 2'd3; // send_ack high

	logic [1:0] state;
	logic [CNT_BITS-1:0] idx;
	logic [MSG_BYTES-1:0][7:0] frame; // cmd byte at top

	// idx only moves with req low, so the byte is stable under req
	assign tx_byte = frame[LAST - idx];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= TX_IDLE;
			idx <= '0;
			tx_req <= 1'b0;
			send_ack <= 1'b0;
		end else begin
			case (state)
				TX_IDLE: if (send_req) begin
					idx <= '0;
					tx_req <= 1'b1;
					state <= TX_BYTE;
				end
				TX_BYTE: if (tx_ack) begin
					tx_req <= 1'b0;
					state <= TX_GAP;
				end
				TX_GAP: if (!tx_ack) begin
					if (idx == LAST) begin
						send_ack <= 1'b1; // whole frame out
						state <= TX_DONE;
					end else begin
						idx <= idx + 1'b1;
						tx_req <= 1'b1;
						state <= TX_BYTE;
					end
				end
				TX_DONE: if (!send_req) begin
					send_ack <= 1'b0; // close the four-phase
					state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// response latched at start, controller may move on after send_ack
	always_ff @(posedge clk_sys) begin
		if (state == TX_IDLE && send_req)
			frame <= {t_cmd, t_a1, t_addr, t_data};
	end

endmodule

`default_nettype wire

// ==== design/msg_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module msg_rx import iob_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        rx_req,
	input  logic [7:0]  rx_byte,
	output logic        rx_ack,
	output logic        msg_valid,
	output msg_cmd_t    m_cmd,
	output logic [7:0]  m_a1,
	output logic [15:0] m_addr,
	output logic [15:0] m_data,
	input  logic        rx_release
);

	localparam int CNT_BITS = $clog2(MSG_BYTES);
	localparam logic [CNT_BITS-1:0] LAST = CNT_BITS'(MSG_BYTES - 1);

	logic [CNT_BITS-1:0] cnt; // position of next byte in frame
	logic take;

	// new byte offered, previous handshake closed, nothing held
	assign take = rx_req && !rx_ack && !msg_valid;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rx_ack <= 1'b0;
			msg_valid <= 1'b0;
			cnt <= '0;
		end else begin
			if (rx_release) begin // controller done, open for next frame
				msg_valid <= 1'b0;
				cnt <= '0;
			end
			if (take) begin
				rx_ack <= 1'b1;
				if (cnt == LAST)
					msg_valid <= 1'b1; // sixth byte in, hold frame
				else
					cnt <= cnt + 1'b1;
			end else if (rx_ack && !rx_req) begin
				rx_ack <= 1'b0; // far end dropped req
			end
		end
	end

	// frame fields, placed by byte position
	always_ff @(posedge clk_sys) begin
		if (take) begin
			case (cnt)
				0: m_cmd <= rx_byte;
				1: m_a1 <= rx_byte;
				2: m_addr[15:8] <= rx_byte; // address high first
				3: m_addr[7:0] <= rx_byte;
				4: m_data[15:8] <= rx_byte;
				5: m_data[7:0] <= rx_byte;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/iob_pkg.sv ====
`default_nettype none

package iob_pkg;

	// frame length on the link, cmd + a1 + addr(2) + data(2)
	localparam int MSG_BYTES = 6;

	// request codes, valid with direction flag set
	typedef enum logic [3:0] {
		req_w = 4'b0010, // write
		req_r = 4'b0011  // read
	} req_code_t;

	// response codes, valid with direction flag clear
	typedef enum logic [3:0] {
		resp_en = 4'b0001, // refused or unknown command
		resp_ok = 4'b0010,
		resp_pe = 4'b0011  // address error
	} resp_code_t;

	// command byte, one byte seen as request or as response
	typedef union packed {
		struct packed {
			logic      dir;  // 1 = request
			logic [2:0] rsvd;
			req_code_t code;
		} req;
		struct packed {
			logic       dir; // 0 = response
			logic [2:0]  rsvd;
			resp_code_t code;
		} resp;
	} msg_cmd_t;

	// slave reply status on the system bus
	typedef enum logic [1:0] {
		bus_none = 2'd0,
		bus_ok   = 2'd1,
		bus_pe   = 2'd2
	} bus_status_t;

endpackage

`default_nettype wire
